// ==== bus_fabric.sv ====
`timescale 1ns/1ps

module bus_fabric import soc_pkg::*; (
    input  logic        clock_50,
    input  logic        key0,
    input  logic [63:0] bus_address,
    input  logic        bus_read_enable,
    input  logic [63:0] key_data,
    input  logic        key_rdy,
    input  logic [63:0] mem_data,
    input  logic        mem_rdy,
    input  logic [63:0] sdb_data,
    input  logic        sdb_rdy,
    input  logic [63:0] con_data_out,
    input  logic        con_rdy,
    output region_t     region,
    output logic        rd_go,
    output logic [63:0] bus_read_data,
    output logic        bus_read_done
);

    // address decode, ranges first
    always_comb begin
        if (bus_address >= ram_base && bus_address < ram_base + ram_size)
            region = rg_ram;
        else if (bus_address >= sdc_base && bus_address < sdc_base + 64'd512)
            region = rg_sdc_cache;
        else if (bus_address == key_base)   region = rg_key;
        else if (bus_address == con_data)   region = rg_con_data;
        else if (bus_address == con_status) region = rg_con_status;
        else if (bus_address == sdc_addr)   region = rg_sdc_addr;
        else if (bus_address == sdc_read)   region = rg_sdc_read;
        else if (bus_address == sdc_ready)  region = rg_sdc_ready;
        else if (bus_address == sdc_avail)  region = rg_sdc_avail;
        else                                region = rg_none;
    end

    // read pulse delayed one edge toward the peripherals
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            rd_go <= 1'b0;
        end else begin
            rd_go <= bus_read_enable;
        end
    end

    // done drops on the pulse, rises with the data
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            bus_read_done <= 1'b1;
        end else if (bus_read_enable) begin
            bus_read_done <= 1'b0;
        end else if (key_rdy || mem_rdy || sdb_rdy || con_rdy) begin
            bus_read_done <= 1'b1;
        end else if (rd_go && region == rg_none) begin
            // nothing mapped here
            bus_read_done <= 1'b1;
        end
    end

    // one rdy at a time, so plain priority is enough
    always_ff @(posedge clock_50) begin
        if (key_rdy)
            bus_read_data <= key_data;
        else if (mem_rdy)
            bus_read_data <= mem_data;
        else if (sdb_rdy)
            bus_read_data <= sdb_data;
        else if (con_rdy)
            bus_read_data <= con_data_out;
        else if (rd_go && region == rg_none)
            bus_read_data <= 64'd0;
    end

endmodule

// ==== console_tx.sv ====
`timescale 1ns/1ps

module console_tx import soc_pkg::*; #(
    parameter int console_credits = 4
) (
    input  logic        clock_50,
    input  logic        key0,
    input  region_t     region,
    input  logic        rd_go,
    input  logic        bus_write_enable,
    input  logic [63:0] bus_write_data,
    input  logic        con_credit,
    output logic        con_valid,
    output logic [7:0]  con_byte,
    output logic [63:0] con_data_out,
    output logic        con_rdy
);

    localparam int cw = $clog2(console_credits + 1);

    logic [cw-1:0] credits;
    logic          send;

    // no free slot means the byte is dropped
    assign send = bus_write_enable && region == rg_con_data && credits != '0;

    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            con_valid <= 1'b0;
            credits   <= cw'(console_credits);
        end else begin
            con_valid <= send;
            // send and return together leave the count as is
            case ({send, con_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clock_50) begin
        if (send)
            con_byte <= bus_write_data[7:0];
    end

    // status read is the free credit count
    assign con_data_out = {{(64 - cw){1'b0}}, credits};
    assign con_rdy      = rd_go && region == rg_con_status;

endmodule

// ==== filelist.f ====
soc_pkg.sv
bus_fabric.sv
main_memory.sv
sd_sector_buffer.sv
key_irq.sv
console_tx.sv
soc_top.sv
tb_soc.sv

// ==== key_irq.sv ====
`timescale 1ns/1ps

module key_irq import soc_pkg::*; (
    input  logic        clock_50,
    input  logic        key0,
    input  region_t     region,
    input  logic        rd_go,
    input  logic        key_pressed,
    input  logic [7:0]  ascii,
    input  logic        irq_ack,
    output logic [63:0] key_data,
    output logic        key_rdy,
    output logic [3:0]  irq_vector
);

    logic       pressed_d;
    logic       press_edge;
    logic [7:0] key_code;

    // rising edge of the decoder's pressed level
    assign press_edge = key_pressed && !pressed_d;

    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            pressed_d  <= 1'b0;
            key_code   <= 8'd0;
            irq_vector <= 4'd0;
        end else begin
            pressed_d <= key_pressed;
            // ack first so a fresh press in the same cycle still wins
            if (irq_ack)
                irq_vector <= 4'd0;
            if (press_edge) begin
                key_code <= ascii;
                // code zero is a press without a printable key
                if (ascii != 8'd0)
                    irq_vector <= 4'd1;
            end
        end
    end

    // latched code for the cpu
    assign key_data = {56'd0, key_code};
    assign key_rdy  = rd_go && region == rg_key;

endmodule

// ==== main_memory.sv ====
`timescale 1ns/1ps

module main_memory import soc_pkg::*; #(
    parameter int mem_words = 2048
) (
    input  logic        clock_50,
    input  logic        key0,
    input  region_t     region,
    input  logic        rd_go,
    input  logic [63:0] bus_address,
    input  access_t     bus_read_type,
    input  logic        bus_write_enable,
    input  access_t     bus_write_type,
    input  logic [63:0] bus_write_data,
    output logic [63:0] mem_data,
    output logic        mem_rdy
);

    localparam int aw = $clog2(mem_words);

    typedef enum logic [1:0] {ms_idle, ms_sd_hi, ms_ld_hi} mem_state_t;

    logic [31:0]   mem [mem_words];
    mem_state_t    state;
    logic [63:0]   offset;
    logic [aw-1:0] word_idx;
    logic [aw-1:0] rd_idx;
    logic [31:0]   rd_word;
    logic [31:0]   shifted;
    logic [31:0]   ld_lo;
    logic [aw-1:0] sd_idx;
    logic [31:0]   sd_hi;
    logic          ram_wr;
    logic          ld_start;

    // byte offset inside the ram window
    assign offset   = bus_address - ram_base;
    assign word_idx = offset[aw+1:2];
    assign ram_wr   = bus_write_enable && region == rg_ram;
    assign ld_start = rd_go && region == rg_ram && bus_read_type == acc_ld;

    // second ld beat reads the next word, address is still held
    assign rd_idx  = (state == ms_ld_hi) ? word_idx + 1'b1 : word_idx;
    assign rd_word = mem[rd_idx];
    // little endian, addressed byte to bit 0
    assign shifted = rd_word >> {offset[1:0], 3'b000};

    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            state <= ms_idle;
        end else begin
            case (state)
                ms_idle: begin
                    if (ram_wr && bus_write_type[1:0] == st_d)
                        state <= ms_sd_hi;
                    else if (ld_start)
                        state <= ms_ld_hi;
                end
                default: state <= ms_idle;
            endcase
        end
    end

    // stores and the captured halves of sd and ld
    always_ff @(posedge clock_50) begin
        if (state == ms_sd_hi)
            mem[sd_idx] <= sd_hi;
        if (ram_wr) begin
            case (bus_write_type[1:0])
                st_b: mem[word_idx][{offset[1:0], 3'b000} +: 8] <= bus_write_data[7:0];
                st_h: mem[word_idx][{offset[1], 4'b0000} +: 16] <= bus_write_data[15:0];
                st_w: mem[word_idx] <= bus_write_data[31:0];
                default: begin
                    // sd, low word now and high word next edge
                    mem[word_idx] <= bus_write_data[31:0];
                    sd_idx <= word_idx + 1'b1;
                    sd_hi  <= bus_write_data[63:32];
                end
            endcase
        end
        if (ld_start)
            ld_lo <= rd_word;
    end

    // load data, sign or zero extended by type
    always_comb begin
        mem_rdy  = 1'b0;
        mem_data = 64'd0;
        if (state == ms_ld_hi) begin
            mem_rdy  = 1'b1;
            mem_data = {rd_word, ld_lo};
        end else if (rd_go && region == rg_ram && bus_read_type != acc_ld) begin
            mem_rdy = 1'b1;
            case (bus_read_type)
                acc_lb:  mem_data = {{56{shifted[7]}}, shifted[7:0]};
                acc_lbu: mem_data = {56'd0, shifted[7:0]};
                acc_lh:  mem_data = {{48{shifted[15]}}, shifted[15:0]};
                acc_lhu: mem_data = {48'd0, shifted[15:0]};
                acc_lw:  mem_data = {{32{shifted[31]}}, shifted};
                acc_lwu: mem_data = {32'd0, shifted};
                default: mem_data = 64'd0;
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run tb_soc with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_soc -f filelist.f -o tb_soc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_soc_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "Result: FAILED" "$log"; then
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

exit 0

// ==== sd_sector_buffer.sv ====
`timescale 1ns/1ps

module sd_sector_buffer import soc_pkg::*; (
    input  logic        clock_50,
    input  logic        key0,
    input  region_t     region,
    input  logic        rd_go,
    input  logic [63:0] bus_address,
    input  logic        bus_write_enable,
    input  logic [63:0] bus_write_data,
    input  logic        sd_ready,
    input  logic        sd_byte_available,
    input  logic [7:0]  sd_dout,
    output logic        sd_rd_start,
    output logic [31:0] sd_addr,
    output logic [63:0] sdb_data,
    output logic        sdb_rdy
);

    logic [7:0]  cache [512];
    logic [8:0]  byte_index;
    logic        cache_avail;
    logic        avail_d;
    logic        byte_edge;
    logic [63:0] cache_off;

    assign byte_edge = sd_byte_available && !avail_d;
    assign cache_off = bus_address - sdc_base;

    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            sd_rd_start <= 1'b0;
            sd_addr     <= 32'd0;
            byte_index  <= 9'd0;
            cache_avail <= 1'b0;
            avail_d     <= 1'b0;
        end else begin
            avail_d <= sd_byte_available;
            if (bus_write_enable && region == rg_sdc_addr)
                sd_addr <= bus_write_data[31:0];
            if (bus_write_enable && region == rg_sdc_read) begin
                // new sector, refill from byte 0
                sd_rd_start <= 1'b1;
                cache_avail <= 1'b0;
                byte_index  <= 9'd0;
            end else if (byte_edge && sd_rd_start) begin
                byte_index <= byte_index + 1'b1;
                // last byte of the sector
                if (byte_index == 9'd511) begin
                    sd_rd_start <= 1'b0;
                    cache_avail <= 1'b1;
                end
            end
        end
    end

    // sector bytes, written at the running index
    always_ff @(posedge clock_50) begin
        if (byte_edge && sd_rd_start)
            cache[byte_index] <= sd_dout;
    end

    // register reads and single cached bytes
    always_comb begin
        sdb_rdy  = 1'b0;
        sdb_data = 64'd0;
        if (rd_go) begin
            case (region)
                rg_sdc_ready: begin
                    sdb_rdy  = 1'b1;
                    sdb_data = {63'd0, sd_ready};
                end
                rg_sdc_avail: begin
                    sdb_rdy  = 1'b1;
                    sdb_data = {63'd0, cache_avail};
                end
                rg_sdc_cache: begin
                    sdb_rdy  = 1'b1;
                    sdb_data = {56'd0, cache[cache_off[8:0]]};
                end
                default: sdb_rdy = 1'b0;
            endcase
        end
    end

endmodule

// ==== soc_pkg.sv ====
package soc_pkg;

    // main memory window
    localparam logic [63:0] ram_base = 64'h0000_0000_0000_1000;
    localparam logic [63:0] ram_size = 64'h0000_0000_0000_2000;

    // single-address device registers
    localparam logic [63:0] key_base   = 64'h0000_0000_0000_4000;
    localparam logic [63:0] con_data   = 64'h0000_0000_0000_4008;
    localparam logic [63:0] con_status = 64'h0000_0000_0000_4010;
    localparam logic [63:0] sdc_addr   = 64'h0000_0000_0000_4020;
    localparam logic [63:0] sdc_read   = 64'h0000_0000_0000_4028;
    localparam logic [63:0] sdc_ready  = 64'h0000_0000_0000_4030;
    localparam logic [63:0] sdc_avail  = 64'h0000_0000_0000_4038;

    // sd sector buffer, 512 byte addresses from here
    localparam logic [63:0] sdc_base = 64'h0000_0000_0000_5000;

    // selected bus target
    typedef enum logic [3:0] {
        rg_none, rg_ram, rg_key, rg_con_data, rg_con_status,
        rg_sdc_addr, rg_sdc_read, rg_sdc_ready, rg_sdc_avail, rg_sdc_cache
    } region_t;

    // load sizes, risc-v funct3 encoding
    typedef enum logic [2:0] {
        acc_lb  = 3'b000,
        acc_lh  = 3'b001,
        acc_lw  = 3'b010,
        acc_ld  = 3'b011,
        acc_lbu = 3'b100,
        acc_lhu = 3'b101,
        acc_lwu = 3'b110
    } access_t;

    // store sizes, decoded from the low two bits of the same field
    localparam logic [1:0] st_b = 2'b00;
    localparam logic [1:0] st_h = 2'b01;
    localparam logic [1:0] st_w = 2'b10;
    localparam logic [1:0] st_d = 2'b11;

endpackage

// ==== soc_top.sv ====
`timescale 1ns/1ps

module soc_top import soc_pkg::*; #(
    parameter int mem_words       = 2048,
    parameter int console_credits = 4
) (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [63:0] bus_address,
    input  logic        bus_read_enable,
    input  access_t     bus_read_type,
    input  logic        bus_write_enable,
    input  access_t     bus_write_type,
    input  logic [63:0] bus_write_data,
    input  logic        key_pressed,
    input  logic [7:0]  ascii,
    input  logic        irq_ack,
    input  logic        sd_ready,
    input  logic        sd_byte_available,
    input  logic [7:0]  sd_dout,
    input  logic        con_credit,
    output logic [63:0] bus_read_data,
    output logic        bus_read_done,
    output logic [3:0]  irq_vector,
    output logic        sd_rd_start,
    output logic [31:0] sd_addr,
    output logic        con_valid,
    output logic [7:0]  con_byte
);

    region_t     region;
    logic        rd_go;
    logic [63:0] key_data;
    logic        key_rdy;
    logic [63:0] mem_data;
    logic        mem_rdy;
    logic [63:0] sdb_data;
    logic        sdb_rdy;
    logic [63:0] con_data_out;
    logic        con_rdy;

    // decode, read handshake and read mux
    bus_fabric u_bus_fabric (
        .clock_50        (CLOCK_50),
        .key0            (KEY0),
        .bus_address     (bus_address),
        .bus_read_enable (bus_read_enable),
        .key_data        (key_data),
        .key_rdy         (key_rdy),
        .mem_data        (mem_data),
        .mem_rdy         (mem_rdy),
        .sdb_data        (sdb_data),
        .sdb_rdy         (sdb_rdy),
        .con_data_out    (con_data_out),
        .con_rdy         (con_rdy),
        .region          (region),
        .rd_go           (rd_go),
        .bus_read_data   (bus_read_data),
        .bus_read_done   (bus_read_done)
    );

    main_memory #(
        .mem_words (mem_words)
    ) u_main_memory (
        .clock_50         (CLOCK_50),
        .key0             (KEY0),
        .region           (region),
        .rd_go            (rd_go),
        .bus_address      (bus_address),
        .bus_read_type    (bus_read_type),
        .bus_write_enable (bus_write_enable),
        .bus_write_type   (bus_write_type),
        .bus_write_data   (bus_write_data),
        .mem_data         (mem_data),
        .mem_rdy          (mem_rdy)
    );

    // sd controller byte stream into the sector buffer
    sd_sector_buffer u_sd_sector_buffer (
        .clock_50          (CLOCK_50),
        .key0              (KEY0),
        .region            (region),
        .rd_go             (rd_go),
        .bus_address       (bus_address),
        .bus_write_enable  (bus_write_enable),
        .bus_write_data    (bus_write_data),
        .sd_ready          (sd_ready),
        .sd_byte_available (sd_byte_available),
        .sd_dout           (sd_dout),
        .sd_rd_start       (sd_rd_start),
        .sd_addr           (sd_addr),
        .sdb_data          (sdb_data),
        .sdb_rdy           (sdb_rdy)
    );

    key_irq u_key_irq (
        .clock_50    (CLOCK_50),
        .key0        (KEY0),
        .region      (region),
        .rd_go       (rd_go),
        .key_pressed (key_pressed),
        .ascii       (ascii),
        .irq_ack     (irq_ack),
        .key_data    (key_data),
        .key_rdy     (key_rdy),
        .irq_vector  (irq_vector)
    );

    // console out with credits from the sink
    console_tx #(
        .console_credits (console_credits)
    ) u_console_tx (
        .clock_50         (CLOCK_50),
        .key0             (KEY0),
        .region           (region),
        .rd_go            (rd_go),
        .bus_write_enable (bus_write_enable),
        .bus_write_data   (bus_write_data),
        .con_credit       (con_credit),
        .con_valid        (con_valid),
        .con_byte         (con_byte),
        .con_data_out     (con_data_out),
        .con_rdy          (con_rdy)
    );

endmodule

// ==== tb_soc.sv ====
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

    localparam int ram_span  = 256;
    localparam int con_slots = 4;
    // rough cycles per test, the watchdog allows ten times the sum
    localparam int test_cycles = 10 + 32 * 2 + 40 * 2 + 49 * 4 + 4 + 2 * 512 + 512 * 4 + 40 + 60;
    localparam int timeout_limit = 10 * test_cycles;

    logic        CLOCK_50;
    logic        KEY0;
    logic [63:0] bus_address;
    logic        bus_read_enable;
    access_t     bus_read_type;
    logic        bus_write_enable;
    access_t     bus_write_type;
    logic [63:0] bus_write_data;
    logic        key_pressed;
    logic [7:0]  ascii;
    logic        irq_ack;
    logic        sd_ready;
    logic        sd_byte_available;
    logic [7:0]  sd_dout;
    logic        con_credit;
    logic [63:0] bus_read_data;
    logic        bus_read_done;
    logic [3:0]  irq_vector;
    logic        sd_rd_start;
    logic [31:0] sd_addr;
    logic        con_valid;
    logic [7:0]  con_byte;

    // byte models of ram and the sd sector
    logic [7:0]  ram_model [ram_span];
    logic [7:0]  sd_model [512];
    logic [7:0]  con_seen [$];
    logic [7:0]  con_sent [$];
    logic [31:0] lfsr;
    int          cycle_count = 0;

    soc_top #(
        .mem_words       (2048),
        .console_credits (con_slots)
    ) u_soc_top (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .bus_address       (bus_address),
        .bus_read_enable   (bus_read_enable),
        .bus_read_type     (bus_read_type),
        .bus_write_enable  (bus_write_enable),
        .bus_write_type    (bus_write_type),
        .bus_write_data    (bus_write_data),
        .key_pressed       (key_pressed),
        .ascii             (ascii),
        .irq_ack           (irq_ack),
        .sd_ready          (sd_ready),
        .sd_byte_available (sd_byte_available),
        .sd_dout           (sd_dout),
        .con_credit        (con_credit),
        .bus_read_data     (bus_read_data),
        .bus_read_done     (bus_read_done),
        .irq_vector        (irq_vector),
        .sd_rd_start       (sd_rd_start),
        .sd_addr           (sd_addr),
        .con_valid         (con_valid),
        .con_byte          (con_byte)
    );

    initial CLOCK_50 = 1'b0;
    always #50 CLOCK_50 = ~CLOCK_50;

    // watchdog
    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_limit);
            $display("Result: FAILED");
            $fatal(1, "run stopped by the watchdog");
        end
    end

    // console sink, one byte per valid pulse
    always @(negedge CLOCK_50) begin
        if (KEY0 && con_valid)
            con_seen.push_back(con_byte);
    end

    // galois lfsr, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // little endian lanes, size from the low two type bits
    function automatic void store_model(input int off, input access_t kind,
                                        input logic [63:0] data);
        int size;
        size = 1 << kind[1:0];
        for (int i = 0; i < size; i++)
            ram_model[off + i] = data[8 * i +: 8];
    endfunction

    function automatic logic [63:0] load_expect(input int off, input access_t kind);
        logic [63:0] v;
        int size;
        v = '0;
        size = 1 << kind[1:0];
        for (int i = 0; i < size; i++)
            v[8 * i +: 8] = ram_model[off + i];
        // top type bit clear means signed
        if (!kind[2]) begin
            case (size)
                1: v = {{56{v[7]}}, v[7:0]};
                2: v = {{48{v[15]}}, v[15:0]};
                4: v = {{32{v[31]}}, v[31:0]};
                default: v = v;
            endcase
        end
        return v;
    endfunction

    task automatic bus_write(input logic [63:0] addr, input access_t kind,
                             input logic [63:0] data);
        @(negedge CLOCK_50);
        bus_address      = addr;
        bus_write_type   = kind;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
    endtask

    // counts falling edges from the pulse until done returns
    task automatic bus_read(input logic [63:0] addr, input access_t kind,
                            output logic [63:0] data);
        int lat;
        int want;
        want = (kind == acc_ld && addr >= ram_base && addr < ram_base + ram_size) ? 3 : 2;
        @(negedge CLOCK_50);
        bus_address     = addr;
        bus_read_type   = kind;
        bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        lat = 1;
        while (!bus_read_done) begin
            @(negedge CLOCK_50);
            lat++;
        end
        check_value(64'(lat), 64'(want), "read latency");
        data = bus_read_data;
    endtask

    initial begin
        logic [63:0] got;
        logic [63:0] data;
        access_t     kind;
        int          off;
        int          size;
        lfsr              = 32'h769e_de92;
        KEY0              = 1'b0;
        bus_address       = '0;
        bus_read_enable   = 1'b0;
        bus_read_type     = acc_lb;
        bus_write_enable  = 1'b0;
        bus_write_type    = acc_lb;
        bus_write_data    = '0;
        key_pressed       = 1'b0;
        ascii             = 8'd0;
        irq_ack           = 1'b0;
        sd_ready          = 1'b1;
        sd_byte_available = 1'b0;
        sd_dout           = 8'd0;
        con_credit        = 1'b0;
        repeat (4) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        check_value(64'(bus_read_done), 64'd1, "done after reset");
        check_value(64'(sd_rd_start), 64'd0, "sd start after reset");
        check_value(64'(irq_vector), 64'd0, "irq after reset");
        check_value(64'(con_valid), 64'd0, "console valid after reset");

        // ram: fill with sd, then random stores of every size
        for (int a = 0; a < ram_span; a += 8) begin
            data = rand_bits(64);
            store_model(a, acc_ld, data);
            bus_write(ram_base + 64'(a), acc_ld, data);
        end
        for (int n = 0; n < 40; n++) begin
            data = rand_bits(2);
            kind = access_t'({1'b0, data[1:0]});
            size = 1 << kind[1:0];
            off  = int'(rand_bits(8)) & ~(size - 1);
            data = rand_bits(64);
            store_model(off, kind, data);
            bus_write(ram_base + 64'(off), kind, data);
        end
        // all seven load types at aligned random offsets
        for (int t = 0; t < 7; t++) begin
            kind = access_t'(t[2:0]);
            size = 1 << kind[1:0];
            for (int n = 0; n < 7; n++) begin
                off = int'(rand_bits(8)) & ~(size - 1);
                bus_read(ram_base + 64'(off), kind, got);
                check_value(got, load_expect(off, kind), "ram load");
            end
        end

        // unmapped address answers zero, no extra beat for ld
        bus_read(64'h0000_0000_0000_8000, acc_ld, got);
        check_value(got, 64'd0, "unmapped read");

        // sd sector read
        data = rand_bits(32);
        bus_write(sdc_addr, acc_ld, data);
        bus_write(sdc_read, acc_ld, 64'd1);
        check_value(64'(sd_rd_start), 64'd1, "sd start level");
        check_value(64'(sd_addr), {32'd0, data[31:0]}, "sd sector address");
        for (int i = 0; i < 512; i++) begin
            data = rand_bits(8);
            sd_model[i] = data[7:0];
            @(negedge CLOCK_50);
            sd_dout           = data[7:0];
            sd_byte_available = 1'b1;
            @(negedge CLOCK_50);
            sd_byte_available = 1'b0;
        end
        check_value(64'(sd_rd_start), 64'd0, "sd start after 512 bytes");
        bus_read(sdc_avail, acc_ld, got);
        check_value(got, 64'd1, "sd available flag");
        bus_read(sdc_ready, acc_ld, got);
        check_value(got, 64'd1, "sd ready level");
        // controller busy, ready must follow the level
        sd_ready = 1'b0;
        bus_read(sdc_ready, acc_ld, got);
        check_value(got, 64'd0, "sd busy level");
        for (int i = 0; i < 512; i++) begin
            bus_read(sdc_base + 64'(i), acc_lbu, got);
            check_value(got, {56'd0, sd_model[i]}, "sd cache byte");
        end

        // keyboard press, ack, then a press with code zero
        @(negedge CLOCK_50);
        ascii       = 8'h5a;
        key_pressed = 1'b1;
        @(negedge CLOCK_50);
        check_value(64'(irq_vector), 64'd1, "irq on key press");
        bus_read(key_base, acc_ld, got);
        check_value(got, 64'h5a, "key code");
        @(negedge CLOCK_50);
        key_pressed = 1'b0;
        irq_ack     = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
        check_value(64'(irq_vector), 64'd0, "irq after ack");
        @(negedge CLOCK_50);
        ascii       = 8'd0;
        key_pressed = 1'b1;
        repeat (2) @(negedge CLOCK_50);
        check_value(64'(irq_vector), 64'd0, "irq on zero code");
        key_pressed = 1'b0;
        bus_read(key_base, acc_ld, got);
        check_value(got, 64'd0, "zero key code");

        // console: six writes, only the credited ones leave
        for (int n = 0; n < 6; n++) begin
            data = rand_bits(8);
            if (n < con_slots)
                con_sent.push_back(data[7:0]);
            bus_write(con_data, acc_ld, data);
        end
        repeat (2) @(negedge CLOCK_50);
        check_value(64'(con_seen.size()), 64'(con_slots), "console bytes sent");
        for (int i = 0; i < con_slots; i++)
            check_value(64'(con_seen[i]), 64'(con_sent[i]), "console byte");
        bus_read(con_status, acc_ld, got);
        check_value(got, 64'd0, "credits when full");
        @(negedge CLOCK_50);
        con_credit = 1'b1;
        @(negedge CLOCK_50);
        con_credit = 1'b0;
        bus_read(con_status, acc_ld, got);
        check_value(got, 64'd1, "credits after return");
        data = rand_bits(8);
        con_sent.push_back(data[7:0]);
        bus_write(con_data, acc_ld, data);
        repeat (2) @(negedge CLOCK_50);
        check_value(64'(con_seen.size()), 64'(con_slots + 1), "console bytes after credit");
        check_value(64'(con_seen[con_slots]), 64'(con_sent[con_slots]), "console byte");
        bus_read(con_status, acc_ld, got);
        check_value(got, 64'd0, "credits after resend");

        $display("Result: PASSED");
        $finish;
    end

endmodule
